/* verilog.f */
hdl/node_cfg_pkg.sv
hdl/node_msg_pkg.sv
hdl/node_store.sv
hdl/store_arbiter.sv
hdl/node_cfg_loader.sv
hdl/node_output_ctrl.sv
hdl/node_ctrl_top.sv
verification/tb_clock_gen.sv
verification/node_ctrl_props.sv
verification/node_ctrl_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the node control testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module node_ctrl_tb \
    -f verilog.f \
    -o node_ctrl_sim

./obj_dir/node_ctrl_sim

/* verification/node_ctrl_tb.sv */
// Loads a random configuration, toggles core outputs, checks every SIGNAL message
// Store contents change only while the controller is idle, except the stall test

module node_ctrl_tb;

    timeunit 1ns;
    timeprecision 1ps;

    // Four times the longest expected run
    localparam int WATCHDOG_NS = 20000;
    localparam int NUM_INSTR   = 16;
    localparam int NUM_OUTPUT  = 6;

    logic        clk;
    logic        reset;
    logic [31:0] in_msg_data;
    logic        in_msg_valid;
    logic        in_msg_ready;
    logic [31:0] out_msg_data;
    logic        out_msg_valid;
    logic        out_msg_ready;
    logic [7:0]  core_outputs;
    logic        idle;

    logic [21:0] store_model [256];
    logic [7:0]  last_outputs;
    logic [31:0] exp_q [$];
    int          ready_mode;

    tb_clock_gen u_tb_clock_gen (.o_clk(clk), .o_reset(reset));

    node_ctrl_top u_node_ctrl_top (
          .i_clk           ( clk           )
        , .i_reset         ( reset         )
        , .i_in_msg_data   ( in_msg_data   )
        , .i_in_msg_valid  ( in_msg_valid  )
        , .o_in_msg_ready  ( in_msg_ready  )
        , .o_out_msg_data  ( out_msg_data  )
        , .o_out_msg_valid ( out_msg_valid )
        , .i_out_msg_ready ( out_msg_ready )
        , .i_core_outputs  ( core_outputs  )
        , .o_idle          ( idle          )
    );

    bind node_ctrl_top node_ctrl_props u_node_ctrl_props (
          .i_clk(i_clk), .i_reset(i_reset)
        , .i_out_msg_data(o_out_msg_data), .i_out_msg_valid(o_out_msg_valid)
        , .i_out_msg_ready(i_out_msg_ready), .i_in_msg_ready(o_in_msg_ready)
        , .i_idle(o_idle), .i_ctrl_rd_en(ctrl_rd_en)
    );

    // ==================================================
    // Helpers
    // ==================================================

    task automatic fail_check(input string text);
        $display("CHECK FAILED at %0t: %s", $time, text);
        $display("** FAIL **");
        $fatal(1, "check failed");
    endtask

    // Header row/column zero, node takes every inbound message
    task automatic send_msg(input logic [1:0] cmd, input logic [21:0] payload);
        in_msg_data  = {8'd0, cmd, payload};
        in_msg_valid = 1'b1;
        while (!in_msg_ready) @(negedge clk);
        @(negedge clk);
        in_msg_valid = 1'b0;
    endtask

    task automatic write_word(input logic [7:0] addr, input logic [21:0] data);
        send_msg(2'd0, {14'd0, addr});
        send_msg(2'd1, data);
        store_model[addr] = data;
    endtask

    // SIGNAL message built from a mapping word and the new output value
    function automatic logic [31:0] signal_msg(input logic [21:0] map, input logic state);
        return {map[13:10], map[9:6], 2'd3, map[5:1], map[0], state, 15'd0};
    endfunction

    // Lowest changed enabled output first, mapping words start through stop
    task automatic apply_outputs(input logic [7:0] value);
        logic [21:0] entry;
        core_outputs = value;
        for (int i = 0; i < NUM_OUTPUT; i++) begin
            if (value[i] != last_outputs[i]) begin
                entry = store_model[8'(NUM_INSTR + i)];
                if (entry[0]) begin
                    for (int a = int'(entry[16:9]); a <= int'(entry[8:1]); a++) begin
                        exp_q.push_back(signal_msg(store_model[a], value[i]));
                    end
                end
                last_outputs[i] = value[i];
            end
        end
    endtask

    task automatic wait_done();
        do @(negedge clk); while (!(exp_q.size() == 0 && idle));
    endtask

    task automatic load_config();
        logic [7:0]  start;
        logic [7:0]  stop;
        int          len;
        send_msg(2'd2, 22'({4'(NUM_OUTPUT), 8'(NUM_INSTR)}));
        for (int k = 0; k < NUM_OUTPUT; k++) begin
            start = 8'(64 + 8 * k);
            len   = (k == 0) ? 4 : 1 + int'($urandom % 4);
            stop  = 8'(int'(start) + len - 1);
            // Output 3 stays inactive
            write_word(8'(NUM_INSTR + k), {5'd0, start, stop, k != 3});
            for (int a = 0; a < len; a++) begin
                write_word(8'(int'(start) + a), {8'd0, 14'($urandom)});
            end
        end
    endtask

    // ==================================================
    // Outbound ready and message check
    // ==================================================

    always @(negedge clk) begin
        logic [31:0] exp_msg;
        case (ready_mode)
            0:       out_msg_ready = 1'b1;
            1:       out_msg_ready = ($urandom % 2) != 0;
            default: out_msg_ready = 1'b0;
        endcase
        // Transfer happens on the coming rising edge
        if (!reset && out_msg_valid && out_msg_ready) begin
            assert (exp_q.size() != 0)
                else fail_check($sformatf("unexpected SIGNAL message %h", out_msg_data));
            exp_msg = exp_q.pop_front();
            assert (out_msg_data == exp_msg)
                else fail_check($sformatf("SIGNAL %h, expected %h", out_msg_data, exp_msg));
        end
    end

    // ==================================================
    // Stimulus
    // ==================================================

    initial begin
        void'($urandom(32'h7a44));
        in_msg_data   = '0;
        in_msg_valid  = 1'b0;
        out_msg_ready = 1'b1;
        core_outputs  = '0;
        last_outputs  = '0;
        ready_mode    = 0;
        @(negedge reset);
        @(negedge clk);
        load_config();

        // Single output, both directions
        apply_outputs(8'h04);
        wait_done();
        apply_outputs(8'h00);
        wait_done();

        // Several at once, plus inactive and disabled outputs
        apply_outputs(8'b1110_1110);
        wait_done();
        apply_outputs(8'b1100_1110);
        wait_done();

        // Random back-pressure
        ready_mode = 1;
        for (int n = 0; n < 6; n++) begin
            apply_outputs(8'($urandom));
            wait_done();
        end

        // Rewrite a mapping word of output 0 while its stream is stalled
        ready_mode = 2;
        apply_outputs(core_outputs ^ 8'h01);
        @(negedge clk);
        send_msg(2'd0, 22'd65);
        send_msg(2'd1, 22'h0012ab);
        store_model[65] = 22'h0012ab;
        repeat (5) @(negedge clk);
        ready_mode = 0;
        wait_done();
        apply_outputs(core_outputs ^ 8'h01);
        wait_done();

        repeat (4) @(negedge clk);
        if (exp_q.size() == 0 && idle) begin
            $display("** PASS **");
            $finish;
        end else begin
            $display("CHECK FAILED at %0t: %0d messages never sent", $time, exp_q.size());
            $display("** FAIL **");
            $fatal(1, "messages missing at end of run");
        end
    end

    initial begin
        #(WATCHDOG_NS * 1ns);
        $display("** FAIL **");
        $fatal(1, "watchdog expired before the tests finished");
    end

endmodule : node_ctrl_tb

/* verification/node_ctrl_props.sv */
// Handshake and arbiter properties, bound into node_ctrl_top
// Internal arbiter nets reach this module through the bind connections

module node_ctrl_props (
      input logic        i_clk
    , input logic        i_reset
    , input logic [31:0] i_out_msg_data
    , input logic        i_out_msg_valid
    , input logic        i_out_msg_ready
    , input logic        i_in_msg_ready
    , input logic        i_idle
    , input logic        i_ctrl_rd_en
);

    timeunit 1ns;
    timeprecision 1ps;

    // ==================================================
    // Reset state
    // ==================================================

    a_reset_state: assert property (@(posedge i_clk)
        i_reset |=> (!i_out_msg_valid && i_idle && i_in_msg_ready))
        else $error("outputs not in reset state after reset");

    // ==================================================
    // Outbound handshake
    // ==================================================

    // Stalled message keeps valid and data
    a_out_hold: assert property (@(posedge i_clk) disable iff (i_reset)
        (i_out_msg_valid && !i_out_msg_ready) |=> (i_out_msg_valid && $stable(i_out_msg_data)))
        else $error("outbound message changed while stalled");

    // ==================================================
    // Arbiter and loader stall
    // ==================================================

    // Held write lands on the first cycle without a controller read
    a_write_lands: assert property (@(posedge i_clk) disable iff (i_reset)
        (!i_in_msg_ready && !i_ctrl_rd_en) |=> i_in_msg_ready)
        else $error("held store write not granted while controller free");

    // Pending write waits out the busy controller
    a_load_stall: assert property (@(posedge i_clk) disable iff (i_reset)
        (!i_in_msg_ready && i_ctrl_rd_en) |=> !i_in_msg_ready)
        else $error("inbound ready rose while controller busy");

endmodule : node_ctrl_props

/* verification/tb_clock_gen.sv */
// 20 ns clock, reset high for the first 3 rising edges
// Reset released on a falling edge like every other input

module tb_clock_gen (
      output logic o_clk
    , output logic o_reset
);

    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        o_clk = 1'b0;
        forever #10 o_clk = ~o_clk;
    end

    initial begin
        o_reset = 1'b1;
        repeat (3) @(posedge o_clk);
        @(negedge o_clk);
        o_reset = 1'b0;
    end

endmodule : tb_clock_gen

/* hdl/node_ctrl_top.sv */
// Node control block, loader and output controller sharing one store
// Inbound messages assumed already routed to this node

module node_ctrl_top (
      input  logic                             i_clk
    , input  logic                             i_reset
    // Inbound message stream
    , input  node_msg_pkg::node_message_t      i_in_msg_data
    , input  logic                             i_in_msg_valid
    , output logic                             o_in_msg_ready
    // Outbound message stream
    , output node_msg_pkg::node_message_t      o_out_msg_data
    , output logic                             o_out_msg_valid
    , input  logic                             i_out_msg_ready
    // Logic core outputs and status
    , input  logic [node_cfg_pkg::OUTPUTS-1:0] i_core_outputs
    , output logic                             o_idle
);

    // Node parameters
    logic [node_cfg_pkg::NODE_PARAM_W-1:0] num_instr;
    logic [node_cfg_pkg::OUTPUT_IDX_W-1:0] num_output;

    // Loader to arbiter
    logic                                  load_wr_req;
    logic [node_cfg_pkg::RAM_ADDR_W-1:0]   load_addr;
    logic [node_cfg_pkg::RAM_DATA_W-1:0]   load_wr_data;
    logic                                  load_wr_grant;

    // Controller to arbiter
    logic [node_cfg_pkg::RAM_ADDR_W-1:0]   ctrl_addr;
    logic                                  ctrl_rd_en;

    // Arbiter to store
    logic [node_cfg_pkg::RAM_ADDR_W-1:0]   ram_addr;
    logic                                  ram_wr_en;
    logic [node_cfg_pkg::RAM_DATA_W-1:0]   ram_wr_data;
    logic                                  ram_rd_en;
    logic [node_cfg_pkg::RAM_DATA_W-1:0]   ram_rd_data;

    node_cfg_loader u_node_cfg_loader (
          .i_clk          ( i_clk          )
        , .i_reset        ( i_reset        )
        , .i_in_msg_data  ( i_in_msg_data  )
        , .i_in_msg_valid ( i_in_msg_valid )
        , .o_in_msg_ready ( o_in_msg_ready )
        , .o_wr_req       ( load_wr_req    )
        , .o_wr_addr      ( load_addr      )
        , .o_wr_data      ( load_wr_data   )
        , .i_wr_grant     ( load_wr_grant  )
        , .o_num_instr    ( num_instr      )
        , .o_num_output   ( num_output     )
    );

    node_output_ctrl u_node_output_ctrl (
          .i_clk           ( i_clk           )
        , .i_reset         ( i_reset         )
        , .o_idle          ( o_idle          )
        , .i_num_instr     ( num_instr       )
        , .i_num_output    ( num_output      )
        , .i_core_outputs  ( i_core_outputs  )
        , .o_ram_addr      ( ctrl_addr       )
        , .o_ram_rd_en     ( ctrl_rd_en      )
        , .i_ram_rd_data   ( ram_rd_data     )
        , .o_out_msg_data  ( o_out_msg_data  )
        , .o_out_msg_valid ( o_out_msg_valid )
        , .i_out_msg_ready ( i_out_msg_ready )
    );

    store_arbiter u_store_arbiter (
          .i_ctrl_rd_en   ( ctrl_rd_en    )
        , .i_ctrl_addr    ( ctrl_addr     )
        , .i_load_wr_req  ( load_wr_req   )
        , .i_load_addr    ( load_addr     )
        , .i_load_wr_data ( load_wr_data  )
        , .o_wr_grant     ( load_wr_grant )
        , .o_addr         ( ram_addr      )
        , .o_wr_en        ( ram_wr_en     )
        , .o_wr_data      ( ram_wr_data   )
        , .o_rd_en        ( ram_rd_en     )
    );

    node_store u_node_store (
          .i_clk     ( i_clk       )
        , .i_reset   ( i_reset     )
        , .i_addr    ( ram_addr    )
        , .i_wr_en   ( ram_wr_en   )
        , .i_wr_data ( ram_wr_data )
        , .i_rd_en   ( ram_rd_en   )
        , .o_rd_data ( ram_rd_data )
    );

endmodule : node_ctrl_top

/* hdl/node_output_ctrl.sv */
// Output change detection and SIGNAL generation, lowest changed index served first
// Store contents must not change while o_idle is low

module node_output_ctrl (
      input  logic                                  i_clk
    , input  logic                                  i_reset
    , output logic                                  o_idle
    // Node parameters from loader
    , input  logic [node_cfg_pkg::NODE_PARAM_W-1:0] i_num_instr
    , input  logic [node_cfg_pkg::OUTPUT_IDX_W-1:0] i_num_output
    // Logic core outputs
    , input  logic [node_cfg_pkg::OUTPUTS-1:0]      i_core_outputs
    // Store read port
    , output logic [node_cfg_pkg::RAM_ADDR_W-1:0]   o_ram_addr
    , output logic                                  o_ram_rd_en
    , input  logic [node_cfg_pkg::RAM_DATA_W-1:0]   i_ram_rd_data
    // Outbound message stream
    , output node_msg_pkg::node_message_t           o_out_msg_data
    , output logic                                  o_out_msg_valid
    , input  logic                                  i_out_msg_ready
);

    typedef enum logic [1:0] { IDLE, LOOKUP, QUERY, SEND } fsm_t;

    fsm_t                                  state_q;
    fsm_t                                  state_d;
    logic [node_cfg_pkg::OUTPUTS-1:0]      outputs_mask;
    logic [node_cfg_pkg::OUTPUTS-1:0]      outputs_last_q;
    logic [node_cfg_pkg::OUTPUTS-1:0]      output_xor;
    logic                                  output_change;
    logic [node_cfg_pkg::OUTPUT_IDX_W-1:0] first_idx;
    logic [node_cfg_pkg::OUTPUT_IDX_W-1:0] idx_q;
    logic                                  flip;
    logic                                  output_value_q;
    node_cfg_pkg::output_lookup_t          lookup;
    node_cfg_pkg::output_lookup_t          pointers_q;
    node_cfg_pkg::output_mapping_t         mapping;
    logic [node_cfg_pkg::RAM_ADDR_W-1:0]   lookup_addr;
    logic [node_cfg_pkg::RAM_ADDR_W-1:0]   rd_addr;
    logic [node_cfg_pkg::RAM_ADDR_W-1:0]   rd_addr_q;
    logic                                  at_stop;
    logic                                  msg_stall;
    logic                                  msg_valid_q;
    node_msg_pkg::node_header_t            msg_hdr;
    node_msg_pkg::signal_payload_t         msg_payload;
    node_msg_pkg::node_message_t           msg_next;
    node_msg_pkg::node_message_t           msg_data_q;

    // ==================================================
    // Change detection
    // ==================================================

    // Only the lowest num_output bits take part
    always_comb begin : comb_mask
        for (int i = 0; i < node_cfg_pkg::OUTPUTS; i++) begin
            outputs_mask[i] = i[node_cfg_pkg::OUTPUT_IDX_W-1:0] < i_num_output;
        end
    end

    assign output_xor    = (i_core_outputs ^ outputs_last_q) & outputs_mask;
    assign output_change = |output_xor;

    // Trailing zero search, lowest set bit wins
    always_comb begin : comb_first_idx
        first_idx = '0;
        for (int i = node_cfg_pkg::OUTPUTS - 1; i >= 0; i--) begin
            if (output_xor[i]) begin
                first_idx = i[node_cfg_pkg::OUTPUT_IDX_W-1:0];
            end
        end
    end

    // Held bit flips once LOOKUP moves on
    assign flip = (state_q == LOOKUP) && !msg_stall;

    // ==================================================
    // FSM
    // ==================================================

    always_comb begin : comb_fsm
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (output_change) state_d = LOOKUP;
            end
            LOOKUP: begin
                if (!msg_stall) state_d = QUERY;
            end
            // Lookup entry on the read port now
            QUERY: begin
                if (lookup.active)      state_d = SEND;
                else if (output_change) state_d = LOOKUP;
                else                    state_d = IDLE;
            end
            SEND: begin
                if (at_stop && !msg_stall) begin
                    state_d = output_change ? LOOKUP : IDLE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            state_q        <= IDLE;
            outputs_last_q <= '0;
            msg_valid_q    <= 1'b0;
        end else begin
            state_q <= state_d;
            // Index is always below OUTPUTS, top bit never set
            if (flip) begin
                outputs_last_q[idx_q[node_cfg_pkg::OUTPUT_IDX_W-2:0]] <=
                    ~outputs_last_q[idx_q[node_cfg_pkg::OUTPUT_IDX_W-2:0]];
            end
            // Valid held through a stall, else one per SEND cycle
            msg_valid_q <= msg_stall || (state_q == SEND);
        end
    end

    // ==================================================
    // Store reads
    // ==================================================

    assign lookup_addr = i_num_instr +
        {{(node_cfg_pkg::RAM_ADDR_W - node_cfg_pkg::OUTPUT_IDX_W){1'b0}}, idx_q};
    assign lookup      = i_ram_rd_data[$bits(node_cfg_pkg::output_lookup_t)-1:0];

    always_comb begin : comb_rd_addr
        rd_addr = rd_addr_q;
        if (!msg_stall) begin
            case (state_q)
                LOOKUP:  rd_addr = lookup_addr;
                QUERY:   rd_addr = lookup.start;
                SEND:    rd_addr = rd_addr_q + 1'b1;
                default: rd_addr = rd_addr_q;
            endcase
        end
    end

    // Word on the read port came from rd_addr_q
    assign at_stop = (rd_addr_q == pointers_q.stop);

    assign o_ram_rd_en = (state_q != IDLE);
    assign o_ram_addr  = rd_addr;

    // ==================================================
    // Message generation
    // ==================================================

    assign msg_stall = msg_valid_q && !i_out_msg_ready;
    assign mapping   = i_ram_rd_data[$bits(node_cfg_pkg::output_mapping_t)-1:0];

    assign msg_hdr.row            = mapping.row;
    assign msg_hdr.column         = mapping.column;
    assign msg_hdr.command        = node_msg_pkg::SIGNAL;
    assign msg_payload.index      = mapping.index;
    assign msg_payload.is_seq     = mapping.is_seq;
    assign msg_payload.state      = output_value_q;
    assign msg_payload.padding    = '0;
    assign msg_next.header        = msg_hdr;
    assign msg_next.payload       = msg_payload;

    // Payload registers
    always_ff @(posedge i_clk) begin
        idx_q     <= first_idx;
        rd_addr_q <= rd_addr;
        if (flip) begin
            output_value_q <= ~outputs_last_q[idx_q[node_cfg_pkg::OUTPUT_IDX_W-2:0]];
        end
        if (state_q == QUERY) begin
            pointers_q <= lookup;
        end
        // Data frozen while stalled
        if (!msg_stall) begin
            msg_data_q <= msg_next;
        end
    end

    // Busy until FSM parked and no change pending
    assign o_idle          = (state_q == IDLE) && !output_change;
    assign o_out_msg_data  = msg_data_q;
    assign o_out_msg_valid = msg_valid_q;

endmodule : node_output_ctrl

/* hdl/node_cfg_loader.sv */
// Inbound message decoder, assumes every message is addressed to this node
// LOAD_DATA is held in a single slot until the arbiter grants the write

module node_cfg_loader (
      input  logic                                  i_clk
    , input  logic                                  i_reset
    // Inbound message stream
    , input  node_msg_pkg::node_message_t           i_in_msg_data
    , input  logic                                  i_in_msg_valid
    , output logic                                  o_in_msg_ready
    // Store write request
    , output logic                                  o_wr_req
    , output logic [node_cfg_pkg::RAM_ADDR_W-1:0]   o_wr_addr
    , output logic [node_cfg_pkg::RAM_DATA_W-1:0]   o_wr_data
    , input  logic                                  i_wr_grant
    // Node parameters
    , output logic [node_cfg_pkg::NODE_PARAM_W-1:0] o_num_instr
    , output logic [node_cfg_pkg::OUTPUT_IDX_W-1:0] o_num_output
);

    logic                                  in_xfer;
    logic                                  hold_valid_q;
    logic [node_cfg_pkg::RAM_DATA_W-1:0]   hold_data_q;
    logic [node_cfg_pkg::RAM_ADDR_W-1:0]   wr_ptr_q;
    logic [node_cfg_pkg::NODE_PARAM_W-1:0] num_instr_q;
    logic [node_cfg_pkg::OUTPUT_IDX_W-1:0] num_output_q;

    // Accept only with an empty holding slot
    assign o_in_msg_ready = !hold_valid_q;
    assign in_xfer        = i_in_msg_valid && o_in_msg_ready;

    // ==================================================
    // Command decode and write pointer
    // ==================================================

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            hold_valid_q <= 1'b0;
            wr_ptr_q     <= '0;
            num_instr_q  <= '0;
            num_output_q <= '0;
        end else if (in_xfer) begin
            case (i_in_msg_data.header.command)
                node_msg_pkg::LOAD_ADDR: begin
                    wr_ptr_q <= i_in_msg_data.payload[node_cfg_pkg::RAM_ADDR_W-1:0];
                end
                node_msg_pkg::LOAD_DATA: begin
                    hold_valid_q <= 1'b1;
                end
                node_msg_pkg::CONFIG: begin
                    num_instr_q  <= i_in_msg_data.payload[node_cfg_pkg::NODE_PARAM_W-1:0];
                    num_output_q <= i_in_msg_data.payload[node_cfg_pkg::NODE_PARAM_W +:
                                                          node_cfg_pkg::OUTPUT_IDX_W];
                end
                // No input handler on this node, SIGNAL is dropped
                default: begin
                end
            endcase
        end else if (hold_valid_q && i_wr_grant) begin
            // Write lands this edge, step to next word
            hold_valid_q <= 1'b0;
            wr_ptr_q     <= wr_ptr_q + 1'b1;
        end
    end

    // Holding slot payload
    always_ff @(posedge i_clk) begin
        if (in_xfer && (i_in_msg_data.header.command == node_msg_pkg::LOAD_DATA)) begin
            hold_data_q <= i_in_msg_data.payload;
        end
    end

    assign o_wr_req     = hold_valid_q;
    assign o_wr_addr    = wr_ptr_q;
    assign o_wr_data    = hold_data_q;
    assign o_num_instr  = num_instr_q;
    assign o_num_output = num_output_q;

endmodule : node_cfg_loader

/* hdl/store_arbiter.sv */
// Fixed priority store arbiter, controller reads always win over loader writes
// Purely combinational, loader must hold its request until granted

module store_arbiter (
    // Output controller, read only
      input  logic                                i_ctrl_rd_en
    , input  logic [node_cfg_pkg::RAM_ADDR_W-1:0] i_ctrl_addr
    // Configuration loader, write only
    , input  logic                                i_load_wr_req
    , input  logic [node_cfg_pkg::RAM_ADDR_W-1:0] i_load_addr
    , input  logic [node_cfg_pkg::RAM_DATA_W-1:0] i_load_wr_data
    , output logic                                o_wr_grant
    // Store port
    , output logic [node_cfg_pkg::RAM_ADDR_W-1:0] o_addr
    , output logic                                o_wr_en
    , output logic [node_cfg_pkg::RAM_DATA_W-1:0] o_wr_data
    , output logic                                o_rd_en
);

    // ==================================================
    // Grant
    // ==================================================

    // Stream in flight must not lose read slots
    assign o_wr_grant = !i_ctrl_rd_en;

    // ==================================================
    // Store drive
    // ==================================================

    assign o_addr    = i_ctrl_rd_en ? i_ctrl_addr : i_load_addr;
    assign o_rd_en   = i_ctrl_rd_en;

    // Write only when loader holds grant
    assign o_wr_en   = i_load_wr_req && o_wr_grant;
    assign o_wr_data = i_load_wr_data;

endmodule : store_arbiter

/* hdl/node_store.sv */
// Single-port configuration RAM, 256 words, one cycle read latency
// Caller must not request read and write in the same cycle

module node_store (
      input  logic                                i_clk
    , input  logic                                i_reset
    , input  logic [node_cfg_pkg::RAM_ADDR_W-1:0] i_addr
    , input  logic                                i_wr_en
    , input  logic [node_cfg_pkg::RAM_DATA_W-1:0] i_wr_data
    , input  logic                                i_rd_en
    , output logic [node_cfg_pkg::RAM_DATA_W-1:0] o_rd_data
);

    // Memory array, no reset
    logic [node_cfg_pkg::RAM_DATA_W-1:0] mem [2**node_cfg_pkg::RAM_ADDR_W];

    always_ff @(posedge i_clk) begin
        if (i_wr_en) begin
            mem[i_addr] <= i_wr_data;
        end
    end

    // Registered read port, holds value between reads
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_rd_data <= '0;
        end else if (i_rd_en) begin
            o_rd_data <= mem[i_addr];
        end
    end

endmodule : node_store

/* hdl/node_msg_pkg.sv */
// 32-bit node message format, header plus 22-bit payload
// SIGNAL payload layout below, all other commands use raw payload bits

package node_msg_pkg;

    localparam int MSG_PAYLOAD_W = 22;

    typedef enum logic [1:0] {
        LOAD_ADDR = 2'd0,
        LOAD_DATA = 2'd1,
        CONFIG    = 2'd2,
        SIGNAL    = 2'd3
    } node_command_t;

    // Target node position and command
    typedef struct packed {
        logic [3:0]    row;
        logic [3:0]    column;
        node_command_t command;
    } node_header_t;

    typedef struct packed {
        node_header_t               header;
        logic [MSG_PAYLOAD_W-1:0]   payload;
    } node_message_t;

    // Output change payload
    typedef struct packed {
        logic [4:0]  index;
        logic        is_seq;
        logic        state;
        logic [14:0] padding;
    } signal_payload_t;

endpackage : node_msg_pkg

/* hdl/node_cfg_pkg.sv */
// Node sizes and configuration store layout, fixed by the 22-bit message payload
// Lookup entries sit at num_instr + output index

package node_cfg_pkg;

    // Core outputs and index width, index must hold OUTPUTS itself
    localparam int OUTPUTS      = 8;
    localparam int OUTPUT_IDX_W = 4;

    // Store geometry
    localparam int RAM_ADDR_W = 8;
    localparam int RAM_DATA_W = 22;

    // Instruction count width
    localparam int NODE_PARAM_W = 8;

    // One entry per output, 17 of 22 bits used
    typedef struct packed {
        logic [7:0] start;
        logic [7:0] stop;
        logic       active;
    } output_lookup_t;

    // One entry per destination, 14 of 22 bits used
    typedef struct packed {
        logic [3:0] row;
        logic [3:0] column;
        logic [4:0] index;
        logic       is_seq;
    } output_mapping_t;

endpackage : node_cfg_pkg
